//--- logic/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int unsigned word_w         = 32;
    localparam int unsigned words_per_line = 4;
    localparam int unsigned line_w         = word_w * words_per_line;  // 128
    localparam int unsigned offset_w       = $clog2(words_per_line);
    localparam int unsigned num_lines      = 8;
    localparam int unsigned index_w        = $clog2(num_lines);
    localparam int unsigned proc_addr_w    = 30;                       // word address
    localparam int unsigned tag_w          = proc_addr_w - index_w - offset_w;
    localparam int unsigned line_addr_w    = proc_addr_w - offset_w;   // memory line address

    // tag above index above offset
    typedef logic [word_w-1:0]      word_t;
    typedef logic [line_w-1:0]      line_t;
    typedef logic [tag_w-1:0]       tag_t;
    typedef logic [index_w-1:0]     index_t;
    typedef logic [offset_w-1:0]    offset_t;
    typedef logic [proc_addr_w-1:0] proc_addr_t;
    typedef logic [line_addr_w-1:0] line_addr_t;

endpackage

//--- logic/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

    // miss handling sequence
    typedef enum logic [1:0] {
        st_idle       = 2'd0,  // lookup, hit service
        st_write_back = 2'd1,  // dirty victim to memory
        st_allocate   = 2'd2   // line fetch
    } cache_state_t;

endpackage

//--- logic/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  cache_geom_pkg::proc_addr_t proc_addr,
    input  cache_geom_pkg::word_t      proc_wdata,
    input  logic                       word_we,
    input  logic                       fill_we,
    input  cache_geom_pkg::line_t      fill_line,
    output logic                       hit,
    output logic                       victim_dirty,
    output cache_geom_pkg::line_addr_t victim_addr,
    output cache_geom_pkg::line_t      victim_line,
    output cache_geom_pkg::word_t      rdata
);
    import cache_geom_pkg::*;

    line_t                data_mem [num_lines];
    tag_t                 tag_mem  [num_lines];
    logic [num_lines-1:0] valid_bits;
    logic [num_lines-1:0] dirty_bits;

    tag_t    tag;
    index_t  index;
    offset_t offset;
    line_t   cur_line;
    line_t   merged_line;

    assign tag    = proc_addr[proc_addr_w-1 -: tag_w];
    assign index  = proc_addr[offset_w +: index_w];
    assign offset = proc_addr[offset_w-1:0];

    assign cur_line = data_mem[index];

    assign hit          = valid_bits[index] && (tag_mem[index] == tag);
    assign victim_dirty = valid_bits[index] && dirty_bits[index];
    assign victim_addr  = {tag_mem[index], index};  // line the index now holds
    assign victim_line  = cur_line;

    // addressed word out of the line
    assign rdata = cur_line[offset*word_w +: word_w];

    // processor word dropped into the current line
    always_comb begin
        merged_line = cur_line;
        merged_line[offset*word_w +: word_w] = proc_wdata;
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[index] <= fill_line;
            tag_mem[index]  <= tag;
        end else if (word_we) begin
            data_mem[index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_we) begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;  // fresh line is clean
        end else if (word_we) begin
            dirty_bits[index] <= 1'b1;
        end
    end

endmodule

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic                       proc_read,
    input  logic                       proc_write,
    input  cache_geom_pkg::proc_addr_t proc_addr,
    input  logic                       hit,
    input  logic                       victim_dirty,
    input  cache_geom_pkg::line_addr_t victim_addr,
    input  cache_geom_pkg::line_t      victim_line,
    input  logic                       mem_ready,
    output logic                       proc_stall,
    output logic                       word_we,
    output logic                       fill_we,
    output logic                       mem_read,
    output logic                       mem_write,
    output cache_geom_pkg::line_addr_t mem_addr,
    output cache_geom_pkg::line_t      mem_wdata
);
    import cache_geom_pkg::*;
    import cache_ctrl_pkg::*;

    cache_state_t state;
    cache_state_t state_nxt;

    logic       req;
    logic       idle_hit;
    line_addr_t req_line_addr;

    assign req           = proc_read || proc_write;
    assign idle_hit      = (state == st_idle) && hit;
    assign req_line_addr = proc_addr[proc_addr_w-1:offset_w];

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (req && !hit) begin
                    if (victim_dirty) begin
                        state_nxt = st_write_back;
                    end else begin
                        state_nxt = st_allocate;
                    end
                end
            end
            st_write_back: begin
                if (mem_ready) begin
                    state_nxt = st_allocate;
                end
            end
            st_allocate: begin
                // request hits once back in idle
                if (mem_ready) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // processor side
    assign proc_stall = req && !idle_hit;
    assign word_we    = proc_write && idle_hit;

    // memory requests held until mem_ready
    assign mem_write = (state == st_write_back);
    assign mem_read  = (state == st_allocate);
    assign fill_we   = mem_read && mem_ready;

    always_comb begin
        if (state == st_write_back) begin
            mem_addr = victim_addr;
        end else begin
            mem_addr = req_line_addr;
        end
    end

    assign mem_wdata = victim_line;  // only sampled during write-back

endmodule

//--- logic/dm_cache.sv
`timescale 1ns/1ps

module dm_cache (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic                       proc_read,
    input  logic                       proc_write,
    input  cache_geom_pkg::proc_addr_t proc_addr,
    input  cache_geom_pkg::word_t      proc_wdata,
    output logic                       proc_stall,
    output cache_geom_pkg::word_t      proc_rdata,
    output logic                       mem_read,
    output logic                       mem_write,
    output cache_geom_pkg::line_addr_t mem_addr,
    output cache_geom_pkg::line_t      mem_wdata,
    input  cache_geom_pkg::line_t      mem_rdata,
    input  logic                       mem_ready
);
    import cache_geom_pkg::*;

    logic       hit;
    logic       victim_dirty;
    line_addr_t victim_addr;
    line_t      victim_line;
    logic       word_we;
    logic       fill_we;

    cache_arrays arrays_inst (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_addr    (proc_addr),
        .proc_wdata   (proc_wdata),
        .word_we      (word_we),
        .fill_we      (fill_we),
        .fill_line    (mem_rdata),  // fill straight from memory
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .rdata        (proc_rdata)
    );

    cache_ctrl ctrl_inst (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .proc_addr    (proc_addr),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .mem_ready    (mem_ready),
        .proc_stall   (proc_stall),
        .word_we      (word_we),
        .fill_we      (fill_we),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

endmodule

//--- testbench/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
    parameter logic [31:0] fill_base = 32'h1000_0000,
    parameter logic [31:0] seed      = 32'h2a1f
) (
    input  logic                       clk,
    input  logic                       proc_reset,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  cache_geom_pkg::line_addr_t mem_addr,
    input  cache_geom_pkg::line_t      mem_wdata,
    output cache_geom_pkg::line_t      mem_rdata,
    output logic                       mem_ready
);
    import cache_geom_pkg::*;

    line_t       lines [64];
    line_t       rdata_q = '0;
    logic        ready_q = 1'b0;
    logic        busy    = 1'b0;
    logic [31:0] rng     = seed;
    int          delay   = 0;
    logic [5:0]  slot;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign slot      = mem_addr[5:0];  // 64 lines wrap
    assign mem_rdata = rdata_q;
    assign mem_ready = ready_q;

    always @(negedge clk) begin
        if (proc_reset) begin
            // word at word address a holds a + fill_base
            for (int i = 0; i < 64; i++) begin
                for (int k = 0; k < 4; k++) begin
                    lines[i][k*32 +: 32] = word_t'(i * 4 + k) + fill_base;
                end
            end
            ready_q <= 1'b0;
            busy = 1'b0;
        end else if (ready_q) begin
            ready_q <= 1'b0;  // one cycle pulse
            busy = 1'b0;
        end else if (mem_read || mem_write) begin
            if (!busy) begin
                rng   = lcg_step(rng);
                delay = 1 + int'(rng[17:16]);  // 1 to 4 cycles
                busy  = 1'b1;
            end
            delay = delay - 1;
            if (delay == 0) begin
                if (mem_write) begin
                    lines[slot] = mem_wdata;
                end
                rdata_q <= lines[slot];
                ready_q <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_dm_cache.sv
`timescale 1ns/1ps

module tb_dm_cache;
    import cache_geom_pkg::*;

    localparam word_t fill_base  = 32'h1000_0000;
    localparam int    req_limit  = 64;
    localparam int    random_ops = 300;

    logic       clk;
    logic       proc_reset;
    logic       proc_read;
    logic       proc_write;
    proc_addr_t proc_addr;
    word_t      proc_wdata;
    logic       proc_stall;
    word_t      proc_rdata;
    logic       mem_read;
    logic       mem_write;
    line_addr_t mem_addr;
    line_t      mem_wdata;
    line_t      mem_rdata;
    logic       mem_ready;

    // reference view of memory contents and cache lines
    word_t                shadow [256];
    tag_t                 model_tag [num_lines];
    logic [num_lines-1:0] model_valid;
    logic [num_lines-1:0] model_dirty;

    index_t     req_idx;
    tag_t       req_tag;
    logic       exp_hit;
    logic       exp_victim_dirty;
    line_addr_t exp_victim_addr;
    word_t      exp_rdata;
    line_t      exp_wb_line;
    logic [5:0] wb_base;

    logic        done_q;
    word_t       rdata_q;
    int          fetches;
    int          write_backs;
    int          errors   = 0;
    int          timeouts = 0;
    logic [31:0] rng;

    dm_cache dm_cache_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    mem_model #(.fill_base(fill_base), .seed(32'h2a1f)) mem_inst (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic note_error(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else note_error(msg);
    endtask

    assign req_idx          = proc_addr[offset_w +: index_w];
    assign req_tag          = proc_addr[proc_addr_w-1 -: tag_w];
    assign exp_hit          = model_valid[req_idx] && (model_tag[req_idx] == req_tag);
    assign exp_victim_dirty = model_valid[req_idx] && model_dirty[req_idx];
    assign exp_victim_addr  = {model_tag[req_idx], req_idx};
    assign exp_rdata        = shadow[proc_addr[7:0]];
    assign wb_base          = mem_addr[5:0];
    assign exp_wb_line      = {shadow[{wb_base, 2'd3}], shadow[{wb_base, 2'd2}],
                               shadow[{wb_base, 2'd1}], shadow[{wb_base, 2'd0}]};

    always @(posedge clk) begin
        if (proc_reset) begin
            for (int a = 0; a < 256; a++) begin
                shadow[a] <= fill_base + word_t'(a);
            end
            model_valid <= '0;
            model_dirty <= '0;
            fetches     <= 0;
            write_backs <= 0;
            done_q      <= 1'b0;
        end else begin
            done_q  <= (proc_read || proc_write) && !proc_stall;
            rdata_q <= proc_rdata;
            if (proc_write && !proc_stall) begin
                shadow[proc_addr[7:0]] <= proc_wdata;
                model_dirty[req_idx]   <= 1'b1;
            end
            if (mem_write && mem_ready) begin
                model_dirty[req_idx] <= 1'b0;  // victim now matches memory
                write_backs <= write_backs + 1;
            end
            if (mem_read && mem_ready) begin
                model_valid[req_idx] <= 1'b1;
                model_tag[req_idx]   <= req_tag;
                fetches <= fetches + 1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        $past(proc_reset) |-> !proc_stall && !mem_read && !mem_write)
        else note_error("stall or memory request active around reset");

    one_request: assert property (@(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write))
        else note_error("mem_read and mem_write high together");

    stall_rule: assert property (@(posedge clk) disable iff (proc_reset)
        (proc_read || proc_write) |-> (proc_stall == !exp_hit))
        else note_error("proc_stall does not match hit or miss");

    read_value: assert property (@(posedge clk) disable iff (proc_reset)
        (proc_read && !proc_stall) |-> (proc_rdata == exp_rdata))
        else note_error("completed read returned wrong data");

    fetch_rule: assert property (@(posedge clk) disable iff (proc_reset)
        mem_read |-> (mem_addr == proc_addr[proc_addr_w-1:offset_w]) && !exp_victim_dirty)
        else note_error("line fetch with wrong address or before write-back");

    wb_rule: assert property (@(posedge clk) disable iff (proc_reset)
        mem_write |-> exp_victim_dirty && !exp_hit && (mem_addr == exp_victim_addr)
                      && (mem_wdata == exp_wb_line))
        else note_error("write-back of wrong line or data");

    hold_rule: assert property (@(posedge clk) disable iff (proc_reset)
        ($past(mem_read || mem_write) && !$past(mem_ready)) |->
            (mem_read == $past(mem_read)) && (mem_write == $past(mem_write))
            && (mem_addr == $past(mem_addr))
            && (!mem_write || mem_wdata == $past(mem_wdata)))
        else note_error("memory request changed before mem_ready");

    // starts and ends on a falling edge
    task automatic run_request(input logic is_write, input proc_addr_t addr,
                               input word_t wdata, output word_t rdata, output int cycles);
        rdata  = '0;
        cycles = 0;
        if (timeouts == 0) begin
            proc_read  = !is_write;
            proc_write = is_write;
            proc_addr  = addr;
            proc_wdata = wdata;
            do begin
                @(negedge clk);
                cycles++;
            end while (!done_q && cycles < req_limit);
            proc_read  = 1'b0;
            proc_write = 1'b0;
            if (done_q) begin
                rdata = rdata_q;
            end else begin
                timeouts++;
                $display("timeout: request to address %0h never completed", addr);
            end
        end
    endtask

    initial begin
        word_t      rd;
        int         cyc;
        int         f0;
        int         w0;
        proc_addr_t addr_a;
        proc_addr_t addr_b;
        rng        = 32'h2a1f;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        repeat (8) @(negedge clk);
        proc_reset = 1'b0;
        repeat (2) @(negedge clk);

        addr_a = 30'h14;
        addr_b = addr_a + 30'd32;  // same index with the next tag

        // read miss and a repeat hit
        f0 = fetches;
        run_request(1'b0, addr_a, '0, rd, cyc);
        expect_true(rd == fill_base + word_t'(addr_a), "read miss returned wrong word");
        expect_true(fetches == f0 + 1, "read miss did not fetch exactly one line");
        run_request(1'b0, addr_a, '0, rd, cyc);
        expect_true(cyc == 1 && fetches == f0 + 1, "repeat read was not a plain hit");

        // write hit then read back
        run_request(1'b1, addr_a, 32'hcafe_0001, rd, cyc);
        expect_true(cyc == 1, "write hit stalled");
        run_request(1'b0, addr_a, '0, rd, cyc);
        expect_true(rd == 32'hcafe_0001, "read after write hit returned wrong word");
        expect_true(fetches == f0 + 1, "write hit caused a memory request");

        // dirty victim goes out before the fetch
        w0 = write_backs;
        run_request(1'b0, addr_b, '0, rd, cyc);
        expect_true(write_backs == w0 + 1, "dirty miss did not write back once");
        expect_true(rd == fill_base + word_t'(addr_b), "dirty miss returned wrong word");
        run_request(1'b0, addr_a, '0, rd, cyc);
        expect_true(rd == 32'hcafe_0001, "written word lost after eviction");

        for (int n = 0; n < random_ops; n++) begin
            rng = lcg_step(rng);
            run_request(rng[28], proc_addr_t'(rng[22:16]), rng, rd, cyc);
        end

        repeat (2) @(negedge clk);
        $display("failed checks: %0d, timed out requests: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dm_cache.f
logic/cache_geom_pkg.sv
logic/cache_ctrl_pkg.sv
logic/cache_arrays.sv
logic/cache_ctrl.sv
logic/dm_cache.sv
testbench/mem_model.sv
testbench/tb_dm_cache.sv

//--- Makefile
TOP = tb_dm_cache

all: run

build:
	verilator --binary --timing --assert -f dm_cache.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

lint:
	verilator --lint-only -Wall \
		logic/cache_geom_pkg.sv logic/cache_ctrl_pkg.sv \
		logic/cache_arrays.sv logic/cache_ctrl.sv logic/dm_cache.sv \
		--top-module dm_cache

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
